// File: rtl/agp_pkg.sv
package agp_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 6;
  localparam int num_regs = 64;
  localparam int num_operands = 3;
  localparam int out_w = 10;

  // operand lanes; W is the destination or the branch offset.
  typedef enum logic [1:0] {
    opnd_a,
    opnd_b,
    opnd_w
  } operand_e;

  typedef enum logic [2:0] {
    op_alu,
    op_shift,
    op_out,
    op_jal,
    op_bz,
    op_bnz,
    op_li,
    op_nop
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_adc,
    alu_sub,
    alu_rdc,
    alu_rdo,
    alu_inc,
    alu_dec,
    alu_mull,
    alu_mulh,
    alu_and,
    alu_or,
    alu_xor,
    alu_eq,
    alu_slt,
    alu_sltu,
    alu_passb
  } alu_func_e;

  // shift kind, taken from the low two function bits.
  localparam logic [1:0] sh_sll = 2'd0;
  localparam logic [1:0] sh_srl = 2'd1;
  localparam logic [1:0] sh_sra = 2'd2;

  localparam logic [5:0] raw_alu = 6'd0;
  localparam logic [5:0] raw_shift = 6'd1;
  localparam logic [5:0] raw_out = 6'd6;
  localparam logic [5:0] raw_jal = 6'd9;
  localparam logic [5:0] raw_bz = 6'd10;
  localparam logic [5:0] raw_bnz = 6'd11;

  localparam int fld_w_imm = 31;
  localparam int fld_w_hi = 30;
  localparam int fld_w_lo = 25;
  localparam int fld_fmt = 24;
  localparam int fld_a_imm = 23;
  localparam int fld_a_hi = 22;
  localparam int fld_a_lo = 17;
  localparam int fld_b_imm = 16;
  localparam int fld_b_hi = 15;
  localparam int fld_b_lo = 10;
  localparam int fld_func_hi = 9;
  localparam int fld_func_lo = 6;
  localparam int fld_opc_hi = 5;
  localparam int fld_opc_lo = 0;
  localparam int fld_li_sign = 23;
  localparam int fld_li_mag_hi = 22;

  localparam logic [xlen-1:0] nop_instr = 32'd63;

endpackage

// File: rtl/fetch_unit.sv
module fetch_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [agp_pkg::xlen-1:0] instr,
  input  logic                     redirect,
  input  logic [agp_pkg::xlen-1:0] redirect_target,
  output logic [agp_pkg::xlen-1:0] pc,
  output logic [agp_pkg::xlen-1:0] id_instr,
  output logic [agp_pkg::xlen-1:0] id_pc
);

  logic [agp_pkg::xlen-1:0] pc_next;

  // a resolved branch in execute wins over the sequential address.
  assign pc_next = redirect ? redirect_target : pc + 'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      id_instr <= agp_pkg::nop_instr;
    end else begin
      pc <= pc_next;
      // the word being fetched is younger than the branch, so it is squashed.
      id_instr <= redirect ? agp_pkg::nop_instr : instr;
    end
    id_pc <= pc;
  end

endmodule

// File: rtl/instr_decode.sv
module instr_decode (
  input  logic [agp_pkg::xlen-1:0]       id_instr,
  input  logic [agp_pkg::xlen-1:0]       id_pc,
  output logic [agp_pkg::reg_addr_w-1:0] opnd_addr [agp_pkg::num_operands],
  output logic [agp_pkg::num_operands-1:0] opnd_is_imm,
  output logic [agp_pkg::xlen-1:0]       opnd_imm [agp_pkg::num_operands],
  output agp_pkg::opcode_e               ex_opcode_in,
  output agp_pkg::alu_func_e             ex_func_in,
  output logic [agp_pkg::xlen-1:0]       ex_pc_in,
  output logic [agp_pkg::xlen-1:0]       li_value,
  output logic [agp_pkg::reg_addr_w-1:0] dest_addr
);

  logic [agp_pkg::xlen-1:0] li_mag;

  always_comb begin
    ex_opcode_in = agp_pkg::op_nop;
    if (id_instr[agp_pkg::fld_fmt]) begin
      // the wide immediate format is only defined with the W flag set.
      if (id_instr[agp_pkg::fld_w_imm]) begin
        ex_opcode_in = agp_pkg::op_li;
      end
    end else begin
      case (id_instr[agp_pkg::fld_opc_hi:agp_pkg::fld_opc_lo])
        agp_pkg::raw_alu:   ex_opcode_in = agp_pkg::op_alu;
        agp_pkg::raw_shift: ex_opcode_in = agp_pkg::op_shift;
        agp_pkg::raw_out:   ex_opcode_in = agp_pkg::op_out;
        agp_pkg::raw_jal:   ex_opcode_in = agp_pkg::op_jal;
        agp_pkg::raw_bz:    ex_opcode_in = agp_pkg::op_bz;
        agp_pkg::raw_bnz:   ex_opcode_in = agp_pkg::op_bnz;
        default:            ex_opcode_in = agp_pkg::op_nop;
      endcase
    end
  end

  always_comb begin
    opnd_addr[agp_pkg::opnd_a] = id_instr[agp_pkg::fld_a_hi:agp_pkg::fld_a_lo];
    opnd_addr[agp_pkg::opnd_b] = id_instr[agp_pkg::fld_b_hi:agp_pkg::fld_b_lo];
    opnd_addr[agp_pkg::opnd_w] = id_instr[agp_pkg::fld_w_hi:agp_pkg::fld_w_lo];
    opnd_is_imm[agp_pkg::opnd_a] = id_instr[agp_pkg::fld_a_imm];
    opnd_is_imm[agp_pkg::opnd_b] = id_instr[agp_pkg::fld_b_imm];
    opnd_is_imm[agp_pkg::opnd_w] = id_instr[agp_pkg::fld_w_imm];
    // an immediate operand is its address field read as a signed number.
    for (int i = 0; i < agp_pkg::num_operands; i++) begin
      opnd_imm[i] = {{(agp_pkg::xlen - agp_pkg::reg_addr_w){opnd_addr[i][agp_pkg::reg_addr_w-1]}},
                     opnd_addr[i]};
    end
  end

  // load-immediate is sign and magnitude.
  assign li_mag = {{(agp_pkg::xlen - agp_pkg::fld_li_mag_hi - 1){1'b0}},
                   id_instr[agp_pkg::fld_li_mag_hi:0]};
  assign li_value = id_instr[agp_pkg::fld_li_sign] ? -li_mag : li_mag;

  assign ex_func_in = agp_pkg::alu_func_e'(id_instr[agp_pkg::fld_func_hi:agp_pkg::fld_func_lo]);
  assign ex_pc_in = id_pc;
  assign dest_addr = id_instr[agp_pkg::fld_w_hi:agp_pkg::fld_w_lo];

endmodule

// File: rtl/reg_file.sv
module reg_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [agp_pkg::reg_addr_w-1:0] rd_addr [agp_pkg::num_operands],
  output logic [agp_pkg::xlen-1:0]       rd_data [agp_pkg::num_operands],
  input  logic                           wr_en,
  input  logic [agp_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [agp_pkg::xlen-1:0]       wr_data
);

  logic [agp_pkg::xlen-1:0] regs [agp_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < agp_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // reads see the old value during a write; the lanes bypass that case.
  always_comb begin
    for (int i = 0; i < agp_pkg::num_operands; i++) begin
      rd_data[i] = regs[rd_addr[i]];
    end
  end

endmodule

// File: rtl/operand_lane.sv
module operand_lane (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           flush,
  input  logic [agp_pkg::reg_addr_w-1:0] addr,
  input  logic                           is_imm,
  input  logic [agp_pkg::xlen-1:0]       imm,
  input  logic [agp_pkg::xlen-1:0]       rd_data,
  input  logic                           wb_en,
  input  logic [agp_pkg::reg_addr_w-1:0] wb_addr,
  input  logic [agp_pkg::xlen-1:0]       wb_data,
  output logic [agp_pkg::xlen-1:0]       operand
);

  logic [agp_pkg::xlen-1:0]       id_value;
  logic [agp_pkg::xlen-1:0]       ex_value;
  logic [agp_pkg::reg_addr_w-1:0] ex_addr;
  logic                           ex_is_imm;

  // decode side. The register being written this cycle is not in the file yet.
  always_comb begin
    if (is_imm) begin
      id_value = imm;
    end else if (wb_en && (wb_addr == addr)) begin
      id_value = wb_data;
    end else begin
      id_value = rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      // an immediate zero never matches a forward.
      ex_is_imm <= 1'b1;
      ex_value <= '0;
    end else begin
      ex_is_imm <= is_imm;
      ex_value <= id_value;
    end
    ex_addr <= addr;
  end

  // execute side picks up the result of the instruction just ahead.
  assign operand = (!ex_is_imm && wb_en && (wb_addr == ex_addr)) ? wb_data : ex_value;

endmodule

// File: rtl/execute_unit.sv
module execute_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  agp_pkg::opcode_e               ex_opcode_in,
  input  agp_pkg::alu_func_e             ex_func_in,
  input  logic [agp_pkg::xlen-1:0]       ex_pc_in,
  input  logic [agp_pkg::xlen-1:0]       li_value,
  input  logic [agp_pkg::reg_addr_w-1:0] dest_addr,
  input  logic [agp_pkg::xlen-1:0]       opnd [agp_pkg::num_operands],
  output logic                           redirect,
  output logic [agp_pkg::xlen-1:0]       redirect_target,
  output logic [agp_pkg::xlen-1:0]       wb_alu,
  output logic [agp_pkg::xlen-1:0]       wb_shift,
  output logic [agp_pkg::xlen-1:0]       wb_link,
  output logic [agp_pkg::xlen-1:0]       wb_li,
  output logic [agp_pkg::reg_addr_w-1:0] wb_dest,
  output logic                           wb_write,
  output agp_pkg::opcode_e               wb_opcode
);

  agp_pkg::opcode_e                  opcode;
  agp_pkg::alu_func_e                func;
  logic [agp_pkg::xlen-1:0]          pc;
  logic [agp_pkg::xlen-1:0]          li_q;
  logic [agp_pkg::reg_addr_w-1:0]    dest;
  logic                              carry;
  logic                              overflow;
  logic                              carry_next;
  logic                              overflow_next;
  logic                              flag_en;
  logic [agp_pkg::xlen-1:0]          a;
  logic [agp_pkg::xlen-1:0]          b;
  logic [agp_pkg::xlen-1:0]          w;
  logic [agp_pkg::xlen:0]            sum;
  logic [agp_pkg::xlen-1:0]          diff;
  logic [2*agp_pkg::xlen-1:0]        prod;
  logic [agp_pkg::xlen-1:0]          alu_res;
  logic [agp_pkg::xlen-1:0]          shift_res;
  logic [$clog2(agp_pkg::xlen)-1:0]  rot;

  assign a = opnd[agp_pkg::opnd_a];
  assign b = opnd[agp_pkg::opnd_b];
  assign w = opnd[agp_pkg::opnd_w];

  // the instruction entering behind a taken branch is squashed here.
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      opcode <= agp_pkg::op_nop;
    end else begin
      opcode <= ex_opcode_in;
    end
    func <= ex_func_in;
    pc <= ex_pc_in;
    li_q <= li_value;
    dest <= dest_addr;
  end

  always_comb begin
    sum = {1'b0, a} + {1'b0, b} + {{agp_pkg::xlen{1'b0}}, carry && (func == agp_pkg::alu_adc)};
    diff = a - b;
    prod = {{agp_pkg::xlen{1'b0}}, a} * {{agp_pkg::xlen{1'b0}}, b};
    carry_next = carry;
    overflow_next = overflow;
    case (func)
      agp_pkg::alu_add: begin
        alu_res = sum[agp_pkg::xlen-1:0];
        carry_next = sum[agp_pkg::xlen];
        overflow_next = (a[agp_pkg::xlen-1] == b[agp_pkg::xlen-1]) &&
                        (sum[agp_pkg::xlen-1] != a[agp_pkg::xlen-1]);
      end
      agp_pkg::alu_adc: begin
        alu_res = sum[agp_pkg::xlen-1:0];
        carry_next = sum[agp_pkg::xlen];
      end
      agp_pkg::alu_sub: begin
        alu_res = diff;
        overflow_next = (a[agp_pkg::xlen-1] != b[agp_pkg::xlen-1]) &&
                        (diff[agp_pkg::xlen-1] != a[agp_pkg::xlen-1]);
      end
      agp_pkg::alu_rdc:   alu_res = {{(agp_pkg::xlen-1){1'b0}}, carry};
      agp_pkg::alu_rdo:   alu_res = {{(agp_pkg::xlen-1){1'b0}}, overflow};
      agp_pkg::alu_inc:   alu_res = a + 'd1;
      agp_pkg::alu_dec:   alu_res = a - 'd1;
      agp_pkg::alu_mull:  alu_res = prod[agp_pkg::xlen-1:0];
      agp_pkg::alu_mulh:  alu_res = prod[2*agp_pkg::xlen-1:agp_pkg::xlen];
      agp_pkg::alu_and:   alu_res = a & b;
      agp_pkg::alu_or:    alu_res = a | b;
      agp_pkg::alu_xor:   alu_res = a ^ b;
      agp_pkg::alu_eq:    alu_res = {{(agp_pkg::xlen-1){1'b0}}, a == b};
      agp_pkg::alu_slt:   alu_res = {{(agp_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      agp_pkg::alu_sltu:  alu_res = {{(agp_pkg::xlen-1){1'b0}}, a < b};
      default:            alu_res = b;
    endcase
  end

  always_comb begin
    rot = b[$clog2(agp_pkg::xlen)-1:0];
    case (func[1:0])
      agp_pkg::sh_sll: shift_res = a << b;
      agp_pkg::sh_srl: shift_res = a >> b;
      agp_pkg::sh_sra: shift_res = $signed(a) >>> b;
      default:         shift_res = (a >> rot) | (a << (agp_pkg::xlen - rot));
    endcase
  end

  // flags only change for instructions that consume the ALU result.
  assign flag_en = opcode inside {agp_pkg::op_alu, agp_pkg::op_out,
                                  agp_pkg::op_bz, agp_pkg::op_bnz};

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
      overflow <= 1'b0;
    end else if (flag_en) begin
      carry <= carry_next;
      overflow <= overflow_next;
    end
  end

  assign redirect = (opcode == agp_pkg::op_jal) ||
                    ((opcode == agp_pkg::op_bz) && (alu_res == '0)) ||
                    ((opcode == agp_pkg::op_bnz) && (alu_res != '0));
  assign redirect_target = (opcode == agp_pkg::op_jal) ? pc + a : pc + w;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_opcode <= agp_pkg::op_nop;
      wb_write <= 1'b0;
    end else begin
      wb_opcode <= opcode;
      wb_write <= opcode inside {agp_pkg::op_alu, agp_pkg::op_shift, agp_pkg::op_out,
                                 agp_pkg::op_jal, agp_pkg::op_li};
    end
    wb_alu <= alu_res;
    wb_shift <= shift_res;
    wb_link <= pc + 'd4;
    wb_li <= li_q;
    wb_dest <= dest;
  end

endmodule

// File: rtl/writeback_unit.sv
module writeback_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [agp_pkg::xlen-1:0]       wb_alu,
  input  logic [agp_pkg::xlen-1:0]       wb_shift,
  input  logic [agp_pkg::xlen-1:0]       wb_link,
  input  logic [agp_pkg::xlen-1:0]       wb_li,
  input  logic [agp_pkg::reg_addr_w-1:0] wb_dest,
  input  logic                           wb_write,
  input  agp_pkg::opcode_e               wb_opcode,
  output logic                           wr_en,
  output logic [agp_pkg::reg_addr_w-1:0] wr_addr,
  output logic [agp_pkg::xlen-1:0]       wr_data,
  output logic [agp_pkg::out_w-1:0]      data_out,
  output logic                           out_valid
);

  always_comb begin
    case (wb_opcode)
      agp_pkg::op_shift: wr_data = wb_shift;
      agp_pkg::op_jal:   wr_data = wb_link;
      agp_pkg::op_li:    wr_data = wb_li;
      default:           wr_data = wb_alu;
    endcase
  end

  assign wr_en = wb_write;
  assign wr_addr = wb_dest;

  // an out instruction also writes its value to the register file.
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= (wb_opcode == agp_pkg::op_out);
      if (wb_opcode == agp_pkg::op_out) begin
        data_out <= wb_alu[agp_pkg::out_w-1:0];
      end
    end
  end

endmodule

// File: rtl/agp_core.sv
module agp_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [agp_pkg::xlen-1:0]  instr,
  output logic [agp_pkg::xlen-1:0]  pc,
  output logic [agp_pkg::out_w-1:0] data_out,
  output logic                      out_valid
);

  logic [agp_pkg::xlen-1:0]         id_instr;
  logic [agp_pkg::xlen-1:0]         id_pc;
  logic                             redirect;
  logic [agp_pkg::xlen-1:0]         redirect_target;
  logic [agp_pkg::reg_addr_w-1:0]   opnd_addr [agp_pkg::num_operands];
  logic [agp_pkg::num_operands-1:0] opnd_is_imm;
  logic [agp_pkg::xlen-1:0]         opnd_imm [agp_pkg::num_operands];
  logic [agp_pkg::xlen-1:0]         rd_data [agp_pkg::num_operands];
  logic [agp_pkg::xlen-1:0]         opnd [agp_pkg::num_operands];
  agp_pkg::opcode_e                 ex_opcode_in;
  agp_pkg::alu_func_e               ex_func_in;
  logic [agp_pkg::xlen-1:0]         ex_pc_in;
  logic [agp_pkg::xlen-1:0]         li_value;
  logic [agp_pkg::reg_addr_w-1:0]   dest_addr;
  logic [agp_pkg::xlen-1:0]         wb_alu;
  logic [agp_pkg::xlen-1:0]         wb_shift;
  logic [agp_pkg::xlen-1:0]         wb_link;
  logic [agp_pkg::xlen-1:0]         wb_li;
  logic [agp_pkg::reg_addr_w-1:0]   wb_dest;
  logic                             wb_write;
  agp_pkg::opcode_e                 wb_opcode;
  logic                             wr_en;
  logic [agp_pkg::reg_addr_w-1:0]   wr_addr;
  logic [agp_pkg::xlen-1:0]         wr_data;

  fetch_unit i_fetch_unit (
    .clk, .rst, .instr, .redirect, .redirect_target, .pc, .id_instr, .id_pc
  );

  instr_decode i_instr_decode (
    .id_instr, .id_pc, .opnd_addr, .opnd_is_imm, .opnd_imm,
    .ex_opcode_in, .ex_func_in, .ex_pc_in, .li_value, .dest_addr
  );

  reg_file i_reg_file (
    .clk, .rst, .rd_addr(opnd_addr), .rd_data, .wr_en, .wr_addr, .wr_data
  );

  for (genvar i = 0; i < agp_pkg::num_operands; i++) begin : g_lane
    operand_lane i_operand_lane (
      .clk, .rst,
      .flush   (redirect),
      .addr    (opnd_addr[i]),
      .is_imm  (opnd_is_imm[i]),
      .imm     (opnd_imm[i]),
      .rd_data (rd_data[i]),
      .wb_en   (wr_en),
      .wb_addr (wr_addr),
      .wb_data (wr_data),
      .operand (opnd[i])
    );
  end

  execute_unit i_execute_unit (
    .clk, .rst, .ex_opcode_in, .ex_func_in, .ex_pc_in, .li_value, .dest_addr, .opnd,
    .redirect, .redirect_target, .wb_alu, .wb_shift, .wb_link, .wb_li,
    .wb_dest, .wb_write, .wb_opcode
  );

  writeback_unit i_writeback_unit (
    .clk, .rst, .wb_alu, .wb_shift, .wb_link, .wb_li, .wb_dest, .wb_write, .wb_opcode,
    .wr_en, .wr_addr, .wr_data, .data_out, .out_valid
  );

endmodule

// File: tests/agp_core_tb.sv
module agp_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int prog_len = 200;
  localparam int cycle_limit = 16 + 4 * prog_len + 50;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [9:0]  data_out;
  logic        out_valid;

  logic [31:0] rng_state;
  logic [31:0] prog [prog_len];
  logic [31:0] model_regs [64];
  logic        model_carry;
  logic        model_ovf;
  logic [9:0]  expected_out [$];
  int          seen;
  int          cycle;
  int          value_errs;
  int          missing_errs;
  int          extra_errs;
  int          reset_errs;

  agp_core i_agp_core (.clk, .rst, .instr, .pc, .data_out, .out_valid);

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = next_random();
    return (r >> 8) % n;
  endfunction

  function automatic logic [31:0] encode_op(input logic w_imm, input logic [5:0] w,
                                            input logic a_imm, input logic [5:0] a,
                                            input logic b_imm, input logic [5:0] b,
                                            input logic [3:0] func, input logic [5:0] opc);
    return {w_imm, w, 1'b0, a_imm, a, b_imm, b, func, opc};
  endfunction

  // register operands stay in r0..r7 so that producers and consumers meet often.
  task automatic pick_operand(output logic is_imm, output logic [5:0] field);
    is_imm = rand_below(2);
    field = is_imm ? 6'(rand_below(64)) : 6'(rand_below(8));
  endtask

  task automatic build_program();
    int          kind;
    int          off;
    logic        a_imm;
    logic        b_imm;
    logic [5:0]  a;
    logic [5:0]  b;
    logic [5:0]  dest;
    logic [5:0]  opc;
    logic [3:0]  func;
    logic [31:0] r;
    for (int i = 0; i < prog_len - 1; i++) begin
      kind = rand_below(100);
      pick_operand(a_imm, a);
      pick_operand(b_imm, b);
      dest = rand_below(8);
      func = rand_below(16);
      opc = 12 + rand_below(52);
      r = next_random();
      // forward offsets in bytes that never pass the last word.
      off = 4 * (1 + rand_below((prog_len - 1 - i < 7) ? prog_len - 1 - i : 7));
      if (kind < 25)
        prog[i] = encode_op(1'b0, dest, a_imm, a, b_imm, b, func, agp_pkg::raw_alu);
      else if (kind < 35)
        prog[i] = encode_op(1'b0, dest, a_imm, a, b_imm, b, func, agp_pkg::raw_shift);
      else if (kind < 60)
        prog[i] = encode_op(1'b0, dest, a_imm, a, b_imm, b, func, agp_pkg::raw_out);
      else if (kind < 68)
        prog[i] = {1'b1, dest, 1'b1, r[23:0]};
      else if (kind < 74)
        prog[i] = encode_op(1'b0, dest, 1'b1, off[5:0], b_imm, b, func, agp_pkg::raw_jal);
      else if (kind < 82)
        prog[i] = encode_op(1'b1, off[5:0], a_imm, a, b_imm, b, func, agp_pkg::raw_bz);
      else if (kind < 90)
        prog[i] = encode_op(1'b1, off[5:0], a_imm, a, b_imm, b, func, agp_pkg::raw_bnz);
      else if (kind < 95)
        prog[i] = encode_op(1'b0, dest, a_imm, a, b_imm, b, func, opc);
      else
        prog[i] = {1'b0, dest, 1'b1, r[23:0]};
    end
    // the last word branches to itself and parks the core.
    prog[prog_len-1] = encode_op(1'b1, 6'd0, 1'b1, 6'd0, 1'b1, 6'd0, 4'd15, agp_pkg::raw_bz);
  endtask

  function automatic logic [31:0] operand_value(input logic is_imm, input logic [5:0] field);
    return is_imm ? {{26{field[5]}}, field} : model_regs[field];
  endfunction

  task automatic alu_model(input logic [3:0] f, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] r);
    logic [32:0] wide;
    logic [63:0] prod;
    int          ia;
    int          ib;
    int          ir;
    longint      s;
    ia = a;
    ib = b;
    prod = {32'd0, a} * {32'd0, b};
    case (f)
      4'd0: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[31:0];
        ir = r;
        s = ia;
        s = s + ib;
        model_carry = wide[32];
        model_ovf = (s != ir);
      end
      4'd1: begin
        wide = {1'b0, a} + {1'b0, b} + {32'd0, model_carry};
        r = wide[31:0];
        model_carry = wide[32];
      end
      4'd2: begin
        r = a - b;
        ir = r;
        s = ia;
        s = s - ib;
        model_ovf = (s != ir);
      end
      4'd3:  r = {31'd0, model_carry};
      4'd4:  r = {31'd0, model_ovf};
      4'd5:  r = a + 1;
      4'd6:  r = a - 1;
      4'd7:  r = prod[31:0];
      4'd8:  r = prod[63:32];
      4'd9:  r = a & b;
      4'd10: r = a | b;
      4'd11: r = a ^ b;
      4'd12: r = {31'd0, a == b};
      4'd13: r = {31'd0, ia < ib};
      4'd14: r = {31'd0, a < b};
      default: r = b;
    endcase
  endtask

  // a rotate right is a window into the word placed twice side by side.
  function automatic logic [31:0] shift_model(input logic [1:0] kind, input logic [31:0] a,
                                              input logic [31:0] b);
    logic signed [31:0] sa;
    logic [4:0]         n;
    logic [63:0]        doubled;
    sa = a;
    n = b[4:0];
    doubled = {a, a};
    case (kind)
      2'd0:    return (b > 31) ? 32'd0 : a << n;
      2'd1:    return (b > 31) ? 32'd0 : a >> n;
      2'd2:    return (b > 31) ? {32{a[31]}} : sa >>> n;
      default: return doubled[n +: 32];
    endcase
  endfunction

  // architectural run of the program, one instruction at a time.
  task automatic run_reference();
    logic [31:0] mpc;
    logic [31:0] next_pc;
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [31:0] res;
    logic [5:0]  wd;
    int          steps;
    mpc = 0;
    steps = 0;
    model_carry = 1'b0;
    model_ovf = 1'b0;
    for (int i = 0; i < 64; i++) model_regs[i] = '0;
    while (mpc[31:2] != prog_len - 1 && steps < 4 * prog_len) begin
      word = prog[mpc[31:2]];
      a = operand_value(word[23], word[22:17]);
      b = operand_value(word[16], word[15:10]);
      w = operand_value(word[31], word[30:25]);
      wd = word[30:25];
      next_pc = mpc + 4;
      if (word[24]) begin
        if (word[31]) model_regs[wd] = word[23] ? -{9'd0, word[22:0]} : {9'd0, word[22:0]};
      end else begin
        case (word[5:0])
          agp_pkg::raw_alu: begin
            alu_model(word[9:6], a, b, res);
            model_regs[wd] = res;
          end
          agp_pkg::raw_shift: model_regs[wd] = shift_model(word[7:6], a, b);
          agp_pkg::raw_out: begin
            alu_model(word[9:6], a, b, res);
            model_regs[wd] = res;
            expected_out.push_back(res[9:0]);
          end
          agp_pkg::raw_jal: begin
            model_regs[wd] = mpc + 4;
            next_pc = mpc + a;
          end
          agp_pkg::raw_bz, agp_pkg::raw_bnz: begin
            alu_model(word[9:6], a, b, res);
            if ((res == 0) == (word[5:0] == agp_pkg::raw_bz)) next_pc = mpc + w;
          end
          default: ;
        endcase
      end
      mpc = next_pc;
      steps++;
    end
    if (expected_out.size() == 0 || steps >= 4 * prog_len) begin
      $display("reference model did not reach the final word with outputs to compare");
      missing_errs++;
    end
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[31:2] < prog_len) return prog[addr[31:2]];
    else return agp_pkg::nop_instr;
  endfunction

  task automatic check_reset();
    if (out_valid !== 1'b0) begin
      $display("CHECK FAILED reset_out_valid expected 0 actual %b", out_valid);
      reset_errs++;
    end
    if (pc !== 32'd0) begin
      $display("CHECK FAILED reset_pc expected %08h actual %08h", 32'd0, pc);
      reset_errs++;
    end
  endtask

  task automatic check_output();
    if (out_valid) begin
      if (seen >= expected_out.size()) begin
        $display("extra output %03h at cycle %0d after all expected outputs", data_out, cycle);
        extra_errs++;
      end else begin
        if (data_out !== expected_out[seen]) begin
          $display("CHECK FAILED out_value[%0d] expected %03h actual %03h",
                   seen, expected_out[seen], data_out);
          value_errs++;
        end
        seen++;
      end
    end
  endtask

  initial begin
    rng_state = 32'hb8c5_f7d4;
    rst = 1'b1;
    instr = agp_pkg::nop_instr;
    seen = 0;
    cycle = 0;
    value_errs = 0;
    missing_errs = 0;
    extra_errs = 0;
    reset_errs = 0;
    build_program();
    run_reference();
    repeat (16) begin
      @(negedge clk);
      cycle++;
      check_reset();
      instr = fetch_word(pc);
    end
    rst = 1'b0;
    while (seen < expected_out.size() && cycle < cycle_limit) begin
      @(negedge clk);
      cycle++;
      check_output();
      instr = fetch_word(pc);
    end
    // a few more cycles catch a stray pulse after the last expected output.
    repeat (8) begin
      @(negedge clk);
      cycle++;
      check_output();
      instr = fetch_word(pc);
    end
    if (seen < expected_out.size()) begin
      $display("cycle limit reached with %0d of %0d expected outputs missing",
               expected_out.size() - seen, expected_out.size());
      missing_errs += expected_out.size() - seen;
    end
    $display("errors: value %0d, missing %0d, extra %0d, reset %0d",
             value_errs, missing_errs, extra_errs, reset_errs);
    if (value_errs + missing_errs + extra_errs + reset_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/agp_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/operand_lane.sv
rtl/execute_unit.sv
rtl/writeback_unit.sv
rtl/agp_core.sv
tests/agp_core_tb.sv
